//--- verilog/coreMgmt_cfg.svh
`ifndef CORE_MGMT_CFG_SVH
`define CORE_MGMT_CFG_SVH

// Bus widths
`define MGMT_ADDR_W 20
`define DATA_W 32
`define CORE_ADDR_W 16

// Region selects on the upper address bits
`define REG_REGION 8'h00
`define CORE_REGION 4'h1

// Register offsets inside the register region
`define CONTROL_ADDR 12'h000
`define IBP_ADDR 12'h004
`define DBP_ADDR 12'h008
`define BPEN_ADDR 12'h00C

// Core local memory depth in words
`define MEM_WORDS 256

`endif

//--- verilog/coreMgmtPkg.sv
`include "coreMgmt_cfg.svh"

package coreMgmtPkg;

	// One master's request, as driven by JTAG or Wishbone
	typedef struct packed {
		logic enable;
		logic writeEnable;
		logic [3:0] byteSelect;
		logic [`MGMT_ADDR_W-1:0] address;
		logic [`DATA_W-1:0] writeData;
	} busRequest_t;

	// Arbitrated internal bus
	typedef struct packed {
		logic we;
		logic oe;
		logic [3:0] byteSelect;
		logic [`MGMT_ADDR_W-1:0] address;
		logic [`DATA_W-1:0] dataWrite;
	} peripheralBus_t;

	// Path into the core local memory
	typedef struct packed {
		logic writeEnable;
		logic [3:0] byteSelect;
		logic [`CORE_ADDR_W-1:0] address;
		logic [`DATA_W-1:0] writeData;
	} coreAccess_t;

	// Which master owns the bus this cycle
	typedef enum logic [1:0] {
		masterNone,
		masterJtag,
		masterWb
	} busMaster_t;

endpackage

//--- verilog/configurationRegister.sv
`timescale 1ns/1ps
`include "coreMgmt_cfg.svh"

module configurationRegister #(
	parameter int WIDTH = 32,
	parameter logic [11:0] ADDRESS = 12'h000,
	parameter logic [WIDTH-1:0] DEFAULT = '0
) (
	input logic clk,
	input logic rstN,
	input logic enable,
	input coreMgmtPkg::peripheralBus_t bus,
	output logic [`DATA_W-1:0] readData,
	output logic requestOutput,
	output logic [WIDTH-1:0] currentValue
);

	logic addressHit;
	logic writeHit;
	logic [WIDTH-1:0] value;

	// Low 12 bits pick the register inside its region
	assign addressHit = enable && (bus.address[11:0] == ADDRESS);
	assign writeHit = addressHit && bus.we;
	assign requestOutput = addressHit && bus.oe;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			value <= DEFAULT;
		end else if (writeHit) begin
			// Each bit follows the byte lane it lives in
			for (int i = 0; i < WIDTH; i++) begin
				if (bus.byteSelect[i / 8]) begin
					value[i] <= bus.dataWrite[i];
				end
			end
		end
	end

	// Zero-extend to the bus width
	always_comb begin
		readData = '0;
		readData[WIDTH-1:0] = value;
	end

	assign currentValue = value;

	// A write with every lane selected lands whole at the next edge
	assert property (@(posedge clk) disable iff (!rstN)
		writeHit && (&bus.byteSelect) |=> value == $past(bus.dataWrite[WIDTH-1:0]));

endmodule

//--- verilog/breakpointUnit.sv
`timescale 1ns/1ps
`include "coreMgmt_cfg.svh"

module breakpointUnit (
	input logic clk,
	input logic rstN,
	input logic enable,
	input coreMgmtPkg::peripheralBus_t bus,
	input logic [`DATA_W-1:0] coreInstructionAddress,
	input logic [`DATA_W-1:0] coreDataAddress,
	output logic [`DATA_W-1:0] readData,
	output logic requestOutput,
	output logic isInstructionAddressBreakpoint,
	output logic isDataAddressBreakpoint
);

	logic [`DATA_W-1:0] instructionBreakpoint;
	logic [`DATA_W-1:0] dataBreakpoint;
	logic [1:0] breakpointEnable;

	logic [`DATA_W-1:0] ibpReadData;
	logic [`DATA_W-1:0] dbpReadData;
	logic [`DATA_W-1:0] bpenReadData;
	logic ibpRequest;
	logic dbpRequest;
	logic bpenRequest;

	configurationRegister #(.WIDTH(32), .ADDRESS(`IBP_ADDR), .DEFAULT(32'h0)) ibpRegister (
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.bus(bus),
		.readData(ibpReadData),
		.requestOutput(ibpRequest),
		.currentValue(instructionBreakpoint)
	);

	configurationRegister #(.WIDTH(32), .ADDRESS(`DBP_ADDR), .DEFAULT(32'h0)) dbpRegister (
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.bus(bus),
		.readData(dbpReadData),
		.requestOutput(dbpRequest),
		.currentValue(dataBreakpoint)
	);

	// Bit 0 arms the instruction compare, bit 1 the data compare
	configurationRegister #(.WIDTH(2), .ADDRESS(`BPEN_ADDR), .DEFAULT(2'b00)) bpenRegister (
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.bus(bus),
		.readData(bpenReadData),
		.requestOutput(bpenRequest),
		.currentValue(breakpointEnable)
	);

	assign requestOutput = ibpRequest || dbpRequest || bpenRequest;

	always_comb begin
		if (ibpRequest) readData = ibpReadData;
		else if (dbpRequest) readData = dbpReadData;
		else readData = bpenReadData;
	end

	// Address comparators
	assign isInstructionAddressBreakpoint = breakpointEnable[0]
		&& (coreInstructionAddress == instructionBreakpoint);
	assign isDataAddressBreakpoint = breakpointEnable[1]
		&& (coreDataAddress == dataBreakpoint);

	// Disarming both compares clears the flags from the next cycle on
	assert property (@(posedge clk) disable iff (!rstN)
		enable && bus.we && bus.byteSelect[0] && bus.address[11:0] == `BPEN_ADDR
			&& bus.dataWrite[1:0] == 2'b00
		|=> !isInstructionAddressBreakpoint && !isDataAddressBreakpoint);

endmodule

//--- verilog/coreManagement.sv
`timescale 1ns/1ps
`include "coreMgmt_cfg.svh"

module coreManagement (
	input logic clk,
	input logic rstN,
	input coreMgmtPkg::busRequest_t jtagRequest,
	input coreMgmtPkg::busRequest_t wbRequest,
	output logic [`DATA_W-1:0] jtagReadData,
	output logic [`DATA_W-1:0] wbReadData,
	output logic wbBusy,
	output logic run,
	output logic interruptEnable,
	input logic [`DATA_W-1:0] coreInstructionAddress,
	input logic [`DATA_W-1:0] coreDataAddress,
	output logic isInstructionAddressBreakpoint,
	output logic isDataAddressBreakpoint,
	output coreMgmtPkg::coreAccess_t coreAccess,
	input logic [`DATA_W-1:0] coreReadData
);

	import coreMgmtPkg::*;

	busMaster_t master;
	busRequest_t selected;
	peripheralBus_t bus;

	logic registerEnable;
	logic coreEnable;
	logic [2:0] control;
	logic [`DATA_W-1:0] controlReadData;
	logic controlRequest;
	logic [`DATA_W-1:0] breakpointReadData;
	logic breakpointRequest;
	logic [`DATA_W-1:0] readData;

	// JTAG always wins
	always_comb begin
		if (jtagRequest.enable) master = masterJtag;
		else if (wbRequest.enable) master = masterWb;
		else master = masterNone;
	end

	always_comb begin
		case (master)
			masterJtag: selected = jtagRequest;
			masterWb: selected = wbRequest;
			default: selected = '0;
		endcase
	end

	// Write data always comes from the selected master
	always_comb begin
		bus.we = selected.enable && selected.writeEnable;
		bus.oe = selected.enable && !selected.writeEnable;
		bus.byteSelect = selected.byteSelect;
		bus.address = selected.address;
		bus.dataWrite = selected.writeData;
	end

	assign wbBusy = jtagRequest.enable && wbRequest.enable;

	// Region decode
	assign registerEnable = bus.address[19:12] == `REG_REGION;
	assign coreEnable = (bus.address[19:16] == `CORE_REGION) && !run;

	// Control bit 0 is run and bit 2 is interrupt enable
	configurationRegister #(.WIDTH(3), .ADDRESS(`CONTROL_ADDR), .DEFAULT(3'b000)) controlRegister (
		.clk(clk),
		.rstN(rstN),
		.enable(registerEnable),
		.bus(bus),
		.readData(controlReadData),
		.requestOutput(controlRequest),
		.currentValue(control)
	);

	breakpointUnit breakpoints (
		.clk(clk),
		.rstN(rstN),
		.enable(registerEnable),
		.bus(bus),
		.coreInstructionAddress(coreInstructionAddress),
		.coreDataAddress(coreDataAddress),
		.readData(breakpointReadData),
		.requestOutput(breakpointRequest),
		.isInstructionAddressBreakpoint(isInstructionAddressBreakpoint),
		.isDataAddressBreakpoint(isDataAddressBreakpoint)
	);

	assign run = control[0];
	assign interruptEnable = control[2];

	// Memory path opens only while the core is halted
	always_comb begin
		coreAccess.writeEnable = coreEnable && bus.we;
		coreAccess.byteSelect = bus.byteSelect;
		coreAccess.address = bus.address[`CORE_ADDR_W-1:0];
		coreAccess.writeData = bus.dataWrite;
	end

	// Core data first, then whichever register answers, else all ones
	always_comb begin
		if (coreEnable) readData = coreReadData;
		else if (controlRequest) readData = controlReadData;
		else if (breakpointRequest) readData = breakpointReadData;
		else readData = '1;
	end

	assign jtagReadData = readData;
	assign wbReadData = readData;

	// A busy Wishbone master holds its request for the next cycle
	assert property (@(posedge clk) disable iff (!rstN)
		wbBusy |=> wbRequest == $past(wbRequest));

	// Run and interrupt enable change only through a control write
	assert property (@(posedge clk) disable iff (!rstN)
		!(registerEnable && bus.we && bus.address[11:0] == `CONTROL_ADDR) |=> $stable(control));

endmodule

//--- verilog/coreLocalMemory.sv
`timescale 1ns/1ps
`include "coreMgmt_cfg.svh"

module coreLocalMemory (
	input logic clk,
	input coreMgmtPkg::coreAccess_t coreAccess,
	output logic [`DATA_W-1:0] readData
);

	localparam int INDEX_W = $clog2(`MEM_WORDS);

	logic [`DATA_W-1:0] memory [`MEM_WORDS];
	logic [INDEX_W-1:0] wordIndex;

	// Byte address in, word index out
	assign wordIndex = coreAccess.address[INDEX_W+1:2];

	always_ff @(posedge clk) begin
		if (coreAccess.writeEnable) begin
			for (int i = 0; i < 4; i++) begin
				if (coreAccess.byteSelect[i]) begin
					memory[wordIndex][i*8 +: 8] <= coreAccess.writeData[i*8 +: 8];
				end
			end
		end
	end

	// Asynchronous read, same cycle as the request
	assign readData = memory[wordIndex];

endmodule

//--- verilog/managementTop.sv
`timescale 1ns/1ps
`include "coreMgmt_cfg.svh"

module managementTop (
	input logic clk,
	input logic rstN,
	input coreMgmtPkg::busRequest_t jtagRequest,
	input coreMgmtPkg::busRequest_t wbRequest,
	output logic [`DATA_W-1:0] jtagReadData,
	output logic [`DATA_W-1:0] wbReadData,
	output logic wbBusy,
	output logic run,
	output logic interruptEnable,
	input logic [`DATA_W-1:0] coreInstructionAddress,
	input logic [`DATA_W-1:0] coreDataAddress,
	output logic isInstructionAddressBreakpoint,
	output logic isDataAddressBreakpoint
);

	import coreMgmtPkg::*;

	coreAccess_t coreAccess;
	logic [`DATA_W-1:0] coreReadData;

	coreManagement management (
		.clk(clk),
		.rstN(rstN),
		.jtagRequest(jtagRequest),
		.wbRequest(wbRequest),
		.jtagReadData(jtagReadData),
		.wbReadData(wbReadData),
		.wbBusy(wbBusy),
		.run(run),
		.interruptEnable(interruptEnable),
		.coreInstructionAddress(coreInstructionAddress),
		.coreDataAddress(coreDataAddress),
		.isInstructionAddressBreakpoint(isInstructionAddressBreakpoint),
		.isDataAddressBreakpoint(isDataAddressBreakpoint),
		.coreAccess(coreAccess),
		.coreReadData(coreReadData)
	);

	coreLocalMemory localMemory (
		.clk(clk),
		.coreAccess(coreAccess),
		.readData(coreReadData)
	);

endmodule

//--- dv/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic rstN
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset held low for the first three rising edges
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

//--- dv/tbTop.sv
`timescale 1ns/1ps
`include "coreMgmt_cfg.svh"

module tbTop;

	import coreMgmtPkg::*;

	localparam int CYCLE_LIMIT = 2000;

	logic clk;
	logic rstN;
	busRequest_t jtagRequest;
	busRequest_t wbRequest;
	logic [`DATA_W-1:0] coreInstructionAddress;
	logic [`DATA_W-1:0] coreDataAddress;
	logic [`DATA_W-1:0] jtagReadData;
	logic [`DATA_W-1:0] wbReadData;
	logic wbBusy;
	logic run;
	logic interruptEnable;
	logic isInstructionAddressBreakpoint;
	logic isDataAddressBreakpoint;

	// Reference model state
	logic [2:0] modelControl;
	logic [`DATA_W-1:0] modelIbp;
	logic [`DATA_W-1:0] modelDbp;
	logic [1:0] modelBpen;
	logic [`DATA_W-1:0] shadow [`MEM_WORDS];
	logic [`DATA_W-1:0] nextIAddr;
	logic [`DATA_W-1:0] nextDAddr;
	busRequest_t pendingReq;

	logic [15:0] lfsrState = 16'd2546;
	int errorCount = 0;
	int cycleCount = 0;

	clockGen clocks (
		.clk(clk),
		.rstN(rstN)
	);

	managementTop i_dut (
		.clk(clk),
		.rstN(rstN),
		.jtagRequest(jtagRequest),
		.wbRequest(wbRequest),
		.jtagReadData(jtagReadData),
		.wbReadData(wbReadData),
		.wbBusy(wbBusy),
		.run(run),
		.interruptEnable(interruptEnable),
		.coreInstructionAddress(coreInstructionAddress),
		.coreDataAddress(coreDataAddress),
		.isInstructionAddressBreakpoint(isInstructionAddressBreakpoint),
		.isDataAddressBreakpoint(isDataAddressBreakpoint)
	);

	// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] result;
		logic newBit;
		result = '0;
		for (int i = 0; i < count; i++) begin
			newBit = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], newBit};
			result = {result[30:0], newBit};
		end
		return result;
	endfunction

	function automatic logic [31:0] mergeBytes(input logic [31:0] oldValue,
			input logic [31:0] newValue, input logic [3:0] lanes);
		logic [31:0] result;
		result = oldValue;
		for (int b = 0; b < 4; b++) begin
			if (lanes[b]) begin
				result[b*8 +: 8] = newValue[b*8 +: 8];
			end
		end
		return result;
	endfunction

	function automatic busRequest_t fullWrite(input logic [19:0] address, input logic [31:0] data);
		busRequest_t r;
		r.enable = 1'b1;
		r.writeEnable = 1'b1;
		r.byteSelect = 4'hF;
		r.address = address;
		r.writeData = data;
		return r;
	endfunction

	// Offsets 0, 4, 8 and C of the register region
	function automatic busRequest_t randomRegisterRequest(input logic write);
		busRequest_t r;
		r.enable = 1'b1;
		r.writeEnable = write;
		r.byteSelect = 4'(randomBits(4));
		r.address = {`REG_REGION, 8'h00, 2'(randomBits(2)), 2'b00};
		r.writeData = randomBits(32);
		return r;
	endfunction

	function automatic busRequest_t randomCoreRequest(input logic write);
		busRequest_t r;
		r.enable = 1'b1;
		r.writeEnable = write;
		r.byteSelect = 4'(randomBits(4));
		r.address = {`CORE_REGION, 6'(randomBits(6)), 8'(randomBits(8)), 2'b00};
		r.writeData = randomBits(32);
		return r;
	endfunction

	// Unused register offsets or regions above the core region
	function automatic busRequest_t randomUnmappedRead();
		busRequest_t r;
		logic [11:0] offset;
		logic [3:0] upper;
		r = '0;
		r.enable = 1'b1;
		r.byteSelect = 4'(randomBits(4));
		if (randomBits(1) == 32'd1) begin
			offset = 12'(randomBits(12));
			if (offset == `CONTROL_ADDR || offset == `IBP_ADDR || offset == `DBP_ADDR
					|| offset == `BPEN_ADDR) begin
				offset = offset ^ 12'h010;
			end
			r.address = {`REG_REGION, offset};
		end else begin
			upper = 4'(randomBits(4));
			if (upper < 4'h2) begin
				upper = upper + 4'h2;
			end
			r.address = {upper, 16'(randomBits(16))};
		end
		return r;
	endfunction

	function automatic logic [31:0] expectedRead(input busRequest_t r);
		if (r.address[19:16] == `CORE_REGION && !modelControl[0]) begin
			return shadow[r.address[9:2]];
		end
		if (r.address[19:12] != `REG_REGION) begin
			return '1;
		end
		case (r.address[11:0])
			`CONTROL_ADDR: return {29'b0, modelControl};
			`IBP_ADDR: return modelIbp;
			`DBP_ADDR: return modelDbp;
			`BPEN_ADDR: return {30'b0, modelBpen};
			default: return '1;
		endcase
	endfunction

	// Applies a write that the DUT registered at this edge
	function automatic void commitWrite(input busRequest_t r);
		logic [31:0] merged;
		if (r.enable && r.writeEnable) begin
			if (r.address[19:16] == `CORE_REGION && !modelControl[0]) begin
				shadow[r.address[9:2]] = mergeBytes(shadow[r.address[9:2]], r.writeData,
					r.byteSelect);
			end else if (r.address[19:12] == `REG_REGION) begin
				case (r.address[11:0])
					`CONTROL_ADDR: begin
						merged = mergeBytes({29'b0, modelControl}, r.writeData, r.byteSelect);
						modelControl = merged[2:0];
					end
					`IBP_ADDR: modelIbp = mergeBytes(modelIbp, r.writeData, r.byteSelect);
					`DBP_ADDR: modelDbp = mergeBytes(modelDbp, r.writeData, r.byteSelect);
					`BPEN_ADDR: begin
						merged = mergeBytes({30'b0, modelBpen}, r.writeData, r.byteSelect);
						modelBpen = merged[1:0];
					end
					default: ;
				endcase
			end
		end
	endfunction

	task automatic reportFailure(input string message);
		errorCount++;
		$display("FAILED at time %0t: %s", $time, message);
		$display("Something failed");
		$fatal(1, "Stopping at the first mismatch");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected) else begin
			reportFailure($sformatf("%s is %h, expected %h", name, actual, expected));
		end
	endtask

	// One bus cycle: drive on the edge, check shortly after
	task automatic runCycle(input busRequest_t jtag, input busRequest_t wb);
		busRequest_t selectedReq;
		logic [31:0] expectRead;
		@(posedge clk);
		commitWrite(pendingReq);
		jtagRequest <= jtag;
		wbRequest <= wb;
		coreInstructionAddress <= nextIAddr;
		coreDataAddress <= nextDAddr;
		if (jtag.enable) begin
			selectedReq = jtag;
		end else if (wb.enable) begin
			selectedReq = wb;
		end else begin
			selectedReq = '0;
		end
		pendingReq = selectedReq;
		expectRead = expectedRead(selectedReq);
		#5;
		checkValue("wbBusy", 32'(wbBusy), 32'(jtag.enable && wb.enable));
		checkValue("run", 32'(run), 32'(modelControl[0]));
		checkValue("interruptEnable", 32'(interruptEnable), 32'(modelControl[2]));
		checkValue("isInstructionAddressBreakpoint", 32'(isInstructionAddressBreakpoint),
			32'(modelBpen[0] && nextIAddr == modelIbp));
		checkValue("isDataAddressBreakpoint", 32'(isDataAddressBreakpoint),
			32'(modelBpen[1] && nextDAddr == modelDbp));
		if (selectedReq.enable && !selectedReq.writeEnable) begin
			checkValue("jtagReadData", jtagReadData, expectRead);
			checkValue("wbReadData", wbReadData, expectRead);
		end
	endtask

	task automatic issueFromEitherMaster(input busRequest_t req);
		if (randomBits(1) == 32'd1) begin
			runCycle(req, '0);
		end else begin
			runCycle('0, req);
		end
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	initial begin
		busRequest_t wbReq;
		busRequest_t readBack;
		int busyCycles;
		jtagRequest = '0;
		wbRequest = '0;
		coreInstructionAddress = '0;
		coreDataAddress = '0;
		nextIAddr = '0;
		nextDAddr = '0;
		pendingReq = '0;
		modelControl = '0;
		modelIbp = '0;
		modelDbp = '0;
		modelBpen = '0;
		while (rstN !== 1'b1) begin
			@(posedge clk);
		end

		// Reset values, control reads back as zero
		runCycle({1'b1, 1'b0, 4'hF, `REG_REGION, `CONTROL_ADDR, 32'h0}, '0);
		checkValue("control after reset", jtagReadData, 32'h0);

		// Register accesses through both masters
		for (int i = 0; i < 300; i++) begin
			issueFromEitherMaster(randomRegisterRequest(randomBits(1) == 32'd1));
		end

		// Collisions, Wishbone holds its write until busy drops
		for (int round = 0; round < 40; round++) begin
			wbReq = randomRegisterRequest(1'b1);
			busyCycles = 1 + int'(randomBits(2));
			for (int c = 0; c < busyCycles; c++) begin
				runCycle(randomRegisterRequest(randomBits(1) == 32'd1), wbReq);
			end
			runCycle('0, wbReq);
			readBack = wbReq;
			readBack.writeEnable = 1'b0;
			runCycle(readBack, '0);
		end

		// Core memory, halted then running
		runCycle(fullWrite({`REG_REGION, `CONTROL_ADDR}, 32'h0), '0);
		for (int w = 0; w < `MEM_WORDS; w++) begin
			runCycle(fullWrite({`CORE_REGION, 6'd0, 8'(w), 2'b00}, randomBits(32)), '0);
		end
		for (int i = 0; i < 300; i++) begin
			issueFromEitherMaster(randomCoreRequest(randomBits(1) == 32'd1));
		end
		runCycle(fullWrite({`REG_REGION, `CONTROL_ADDR}, 32'h1), '0);
		for (int i = 0; i < 100; i++) begin
			issueFromEitherMaster(randomCoreRequest(randomBits(1) == 32'd1));
		end
		runCycle('0, fullWrite({`REG_REGION, `CONTROL_ADDR}, 32'h0));
		for (int i = 0; i < 100; i++) begin
			issueFromEitherMaster(randomCoreRequest(1'b0));
		end

		// Unmapped space
		for (int i = 0; i < 60; i++) begin
			issueFromEitherMaster(randomUnmappedRead());
		end

		// Breakpoint compares
		for (int round = 0; round < 20; round++) begin
			runCycle(fullWrite({`REG_REGION, `IBP_ADDR}, randomBits(32)), '0);
			runCycle('0, fullWrite({`REG_REGION, `DBP_ADDR}, randomBits(32)));
			runCycle(fullWrite({`REG_REGION, `BPEN_ADDR}, randomBits(2)), '0);
			for (int c = 0; c < 8; c++) begin
				// Roughly half the addresses hit the stored values
				nextIAddr = (randomBits(1) == 32'd1) ? modelIbp : randomBits(32);
				nextDAddr = (randomBits(1) == 32'd1) ? modelDbp : randomBits(32);
				runCycle('0, '0);
			end
		end

		runCycle('0, '0);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+verilog
verilog/coreMgmtPkg.sv
verilog/configurationRegister.sv
verilog/breakpointUnit.sv
verilog/coreManagement.sv
verilog/coreLocalMemory.sv
verilog/managementTop.sv
dv/clockGen.sv
dv/tbTop.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f tb.f

# The simulator's own status is ignored; the pass line decides
output=$(./obj_dir/VtbTop || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
